// File: all.f
+incdir+include
verilog/fetch_pkg.sv
verilog/instr_mem.sv
verilog/jal_predecoder.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
sim/tb_fetch.sv

// File: sim/tb_fetch.sv
`timescale 1ns/1ns
/*
 * Directed testbench for the fetch front end
 * Program image model, compare tasks, LCG stimulus and watchdog
 */
`include "fetch_defines.svh"

module tb_fetch;

    import fetch_pkg::*;

    localparam int         TEST_CYCLES = 400;
    localparam logic [6:0] JAL_MAJOR   = 7'b1101111;
    localparam word_t      JAL_PC      = 32'h0000_0300;
    localparam int         JAL_IMM     = -752;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        sys_reset_i;
    logic        enable_i;
    logic        jump_i;
    word_t       jump_target_i;
    word_t       mtvec_i;
    word_t       mepc_i;
    logic        exception_raised_i;
    logic        machine_return_i;
    logic        interrupt_ack_i;
    logic        imem_write_en_i;
    imem_index_t imem_write_index_i;
    word_t       imem_write_data_i;
    word_t       instruction_o;
    word_t       pc_o;
    tag_t        tag_o;
    logic        jumping_o;
    logic        predicted_o;

    // Mirror of everything written into the instruction memory
    word_t       model [2 ** `IMEM_ADDR_BITS];
    logic [31:0] lcg_state;
    word_t       expected_pc;
    tag_t        expected_tag;
    int          pulse_count;

    fetch_top UUT (.*);

    always #4 clk = ~clk;

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s = %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_tag(input string name, input tag_t actual, input tag_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s = %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s = %h, expected %h", name, actual, expected));
        end
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random word, never a JAL
    function automatic word_t random_word();
        word_t hi;
        word_t lo;
        word_t w;
        hi = lcg_next();
        lo = lcg_next();
        w = {hi[31:16], lo[31:16]};
        if (w[6:0] == JAL_MAJOR) begin
            w[3] = ~w[3];
        end
        return w;
    endfunction

    // jal x1, imm
    function automatic word_t encode_jal(input int imm);
        logic [20:0] i;
        i = imm[20:0];
        return {i[20], i[10:1], i[11], i[19:12], 5'd1, JAL_MAJOR};
    endfunction

    task automatic load_program();
        word_t data;
        for (int i = 0; i < 2 ** `IMEM_ADDR_BITS; i++) begin
            data = (i == JAL_PC[`IMEM_ADDR_BITS+1:2]) ? encode_jal(JAL_IMM) : random_word();
            model[i] = data;
            @(posedge clk);
            imem_write_en_i    <= 1'b1;
            imem_write_index_i <= i[`IMEM_ADDR_BITS-1:0];
            imem_write_data_i  <= data;
        end
        @(posedge clk);
        imem_write_en_i <= 1'b0;
    endtask

    task automatic check_reset_state();
        check_bit("jumping_o", jumping_o, 1'b1);
        check_tag("tag_o", tag_o, '1);
        check_word("instruction_o", instruction_o, `NOP_WORD);
        check_word("pc_o", pc_o, `FETCH_START_ADDRESS);
        check_bit("predicted_o", predicted_o, 1'b0);
    endtask

    // Valid word on the outputs must be the expected one
    task automatic check_presented();
        check_bit("jumping_o", jumping_o, 1'b0);
        check_word("pc_o", pc_o, expected_pc);
        check_word("instruction_o", instruction_o, model[expected_pc[`IMEM_ADDR_BITS+1:2]]);
        check_tag("tag_o", tag_o, expected_tag);
        expected_pc = expected_pc + 32'd4;
    endtask

    task automatic next_valid();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            @(negedge clk);
            waited++;
            if (predicted_o) begin
                pulse_count++;
            end
            if (waited > 6) begin
                abort_run("No valid instruction was presented within 6 cycles");
            end
        end while (jumping_o);
        check_presented();
    endtask

    // One-cycle redirect request, each counts as one tag step
    task automatic redirect(input logic exc, input logic jmp, input logic mret, input word_t target);
        @(posedge clk);
        exception_raised_i <= exc;
        jump_i             <= jmp;
        machine_return_i   <= mret;
        jump_target_i      <= target;
        @(posedge clk);
        exception_raised_i <= 1'b0;
        jump_i             <= 1'b0;
        machine_return_i   <= 1'b0;
        expected_tag = expected_tag + 1'b1;
    endtask

    task automatic stall_for(input int len);
        word_t held_pc;
        word_t held_instr;
        tag_t  held_tag;
        @(posedge clk);
        enable_i <= 1'b0;
        @(negedge clk);
        held_pc    = pc_o;
        held_instr = instruction_o;
        held_tag   = tag_o;
        check_presented();
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            if (i == len - 1) begin
                enable_i <= 1'b1;
            end
            @(negedge clk);
            check_word("pc_o", pc_o, held_pc);
            check_word("instruction_o", instruction_o, held_instr);
            check_tag("tag_o", tag_o, held_tag);
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_sequential();
        expected_pc  = `FETCH_START_ADDRESS;
        expected_tag = '0;
        @(posedge clk);
        enable_i <= 1'b1;
        repeat (8) next_valid();
    endtask

    task automatic test_stalls();
        repeat (4) begin
            stall_for((lcg_next() >> 16) % 4 + 1);
            next_valid();
            next_valid();
        end
    endtask

    task automatic test_jump();
        redirect(1'b0, 1'b1, 1'b0, 32'h0000_0142);
        expected_pc = 32'h0000_0140;
        repeat (3) next_valid();
    endtask

    task automatic test_trap_priority();
        redirect(1'b1, 1'b1, 1'b1, 32'h0000_0100);
        expected_pc = {mepc_i[31:2], 2'b00};
        repeat (2) next_valid();
        redirect(1'b1, 1'b1, 1'b0, 32'h0000_0100);
        expected_pc = {mtvec_i[31:2], 2'b00};
        repeat (2) next_valid();
    endtask

    task automatic test_predicted_jal();
        redirect(1'b0, 1'b1, 1'b0, JAL_PC - 32'd8);
        expected_pc = JAL_PC - 32'd8;
        pulse_count = 0;
        repeat (3) next_valid();
        check_bit("predicted_o", predicted_o, 1'b1);
        expected_pc  = JAL_PC + word_t'(JAL_IMM);
        expected_tag = expected_tag + 1'b1;
        next_valid();
        if (pulse_count != 1) begin
            abort_run($sformatf("predicted_o pulsed %0d times for one JAL", pulse_count));
        end
        next_valid();
    endtask

    task automatic test_sys_reset();
        @(posedge clk);
        sys_reset_i <= 1'b1;
        @(posedge clk);
        sys_reset_i <= 1'b0;
        @(negedge clk);
        check_reset_state();
        expected_pc  = `FETCH_START_ADDRESS;
        expected_tag = '0;
        repeat (3) next_valid();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        lcg_state          = 32'd51368;
        pulse_count        = 0;
        reset_n            = 1'b0;
        sys_reset_i        = 1'b0;
        enable_i           = 1'b0;
        jump_i             = 1'b0;
        jump_target_i      = '0;
        mtvec_i            = 32'h0000_0280;
        mepc_i             = 32'h0000_0203;
        exception_raised_i = 1'b0;
        machine_return_i   = 1'b0;
        interrupt_ack_i    = 1'b0;
        imem_write_en_i    = 1'b0;
        imem_write_index_i = '0;
        imem_write_data_i  = '0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_reset_state();
        // Fetch stays parked at the start address while loading
        load_program();
        test_sequential();
        test_stalls();
        test_jump();
        test_trap_priority();
        test_predicted_jal();
        test_sys_reset();
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 100) * 8);
        abort_run("Watchdog timeout, the tests did not finish in time");
    end

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/1ns
/*
 * Fetch front end top level
 * Fetch unit, instruction memory and JAL predecoder
 */

module fetch_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sys_reset_i,
    input  logic                    enable_i,

    // Redirects from the core
    input  logic                    jump_i,
    input  fetch_pkg::word_t        jump_target_i,
    input  fetch_pkg::word_t        mtvec_i,
    input  fetch_pkg::word_t        mepc_i,
    input  logic                    exception_raised_i,
    input  logic                    machine_return_i,
    input  logic                    interrupt_ack_i,

    // Program load
    input  logic                    imem_write_en_i,
    input  fetch_pkg::imem_index_t  imem_write_index_i,
    input  fetch_pkg::word_t        imem_write_data_i,

    // To decode
    output fetch_pkg::word_t        instruction_o,
    output fetch_pkg::word_t        pc_o,
    output fetch_pkg::tag_t         tag_o,
    output logic                    jumping_o,
    output logic                    predicted_o
);

    import fetch_pkg::*;

    word_t       instruction_address;
    word_t       instruction_data;
    imem_index_t read_index;
    logic        predict_take;
    word_t       predict_target;

    // Byte address to word index
    assign read_index  = instruction_address[$bits(imem_index_t)+1:2];
    assign predicted_o = predict_take;

    instr_mem u_instr_mem (
        .clk            (clk),
        .read_index_i   (read_index),
        .read_data_o    (instruction_data),
        .write_en_i     (imem_write_en_i),
        .write_index_i  (imem_write_index_i),
        .write_data_i   (imem_write_data_i)
    );

    // Stale words never predict, and only a leaving word may
    jal_predecoder u_jal_predecoder (
        .bubble_i       (jumping_o),
        .advance_i      (enable_i),
        .instruction_i  (instruction_o),
        .pc_i           (pc_o),
        .take_o         (predict_take),
        .target_o       (predict_target)
    );

    fetch_unit u_fetch_unit (
        .clk                    (clk),
        .reset_n                (reset_n),
        .sys_reset_i            (sys_reset_i),
        .enable_i               (enable_i),
        .jump_i                 (jump_i),
        .jump_target_i          (jump_target_i),
        .bp_take_i              (predict_take),
        .bp_target_i            (predict_target),
        .mtvec_i                (mtvec_i),
        .mepc_i                 (mepc_i),
        .exception_raised_i     (exception_raised_i),
        .machine_return_i       (machine_return_i),
        .interrupt_ack_i        (interrupt_ack_i),
        .instruction_address_o  (instruction_address),
        .instruction_data_i     (instruction_data),
        .instruction_o          (instruction_o),
        .pc_o                   (pc_o),
        .tag_o                  (tag_o),
        .jumping_o              (jumping_o)
    );

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ns
/*
 * Instruction fetch unit
 * Address register with redirect priority, stale-word tracking,
 * PC of the presented word, stall holding and the redirect tag
 */
`include "fetch_defines.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              sys_reset_i,
    input  logic              enable_i,

    // Redirect sources
    input  logic              jump_i,
    input  fetch_pkg::word_t  jump_target_i,
    input  logic              bp_take_i,
    input  fetch_pkg::word_t  bp_target_i,
    input  fetch_pkg::word_t  mtvec_i,
    input  fetch_pkg::word_t  mepc_i,
    input  logic              exception_raised_i,
    input  logic              machine_return_i,
    input  logic              interrupt_ack_i,

    // Memory side
    output fetch_pkg::word_t  instruction_address_o,
    input  fetch_pkg::word_t  instruction_data_i,

    // Presented instruction
    output fetch_pkg::word_t  instruction_o,
    output fetch_pkg::word_t  pc_o,
    output fetch_pkg::tag_t   tag_o,
    output logic              jumping_o
);

    import fetch_pkg::*;

    logic  trap_taken;
    logic  should_jump;
    logic  jumped;
    logic  jumped_r;
    logic  jumped_r2;
    logic  enable_r;
    word_t jump_target;
    word_t iaddr_next;
    word_t iaddr_aligned;
    word_t iaddr_jumped;
    word_t iaddr_jumped_r;
    word_t pc_update;
    word_t idata_held;
    word_t instruction_fetched;
    tag_t  tag;
    tag_t  tag_r;

    ////////////////////
    // Address control
    ////////////////////

    assign trap_taken  = exception_raised_i || interrupt_ack_i;
    assign should_jump = jump_i || bp_take_i;
    assign jump_target = jump_i ? jump_target_i : bp_target_i;
    assign jumped      = machine_return_i || trap_taken || should_jump;

    // mret over trap over external jump over predicted JAL
    always_comb begin
        if (machine_return_i) begin
            iaddr_next = mepc_i;
        end else if (trap_taken) begin
            iaddr_next = mtvec_i;
        end else if (should_jump) begin
            iaddr_next = jump_target;
        end else if (enable_i) begin
            iaddr_next = instruction_address_o + 32'd4;
        end else begin
            iaddr_next = instruction_address_o;
        end
    end

    // No compressed support so fetch stays word aligned
    assign iaddr_aligned = {iaddr_next[31:2], 2'b00};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_address_o <= `FETCH_START_ADDRESS;
        end else if (sys_reset_i) begin
            instruction_address_o <= `FETCH_START_ADDRESS;
        end else begin
            instruction_address_o <= iaddr_aligned;
        end
    end

    ////////////////////
    // Jump tracking
    ////////////////////

    // jumped_r marks the word in memory and jumped_r2 the word being presented
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r  <= 1'b1;
            jumped_r2 <= 1'b1;
            jumping_o <= 1'b1;
        end else if (sys_reset_i) begin
            jumped_r  <= 1'b1;
            jumped_r2 <= 1'b1;
            jumping_o <= 1'b1;
        end else begin
            if (jumped) begin
                jumped_r <= 1'b1;
            end else if (enable_i) begin
                jumped_r <= 1'b0;
            end
            if (enable_i) begin
                jumped_r2 <= jumped_r;
            end
            // Covers both stale words in flight
            if (jumped || jumped_r) begin
                jumping_o <= 1'b1;
            end else if (enable_i) begin
                jumping_o <= 1'b0;
            end
        end
    end

    ////////////////////
    // PC control
    ////////////////////

    // Redirect target follows its word down the pipe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            iaddr_jumped   <= `FETCH_START_ADDRESS;
            iaddr_jumped_r <= `FETCH_START_ADDRESS;
        end else if (sys_reset_i) begin
            iaddr_jumped   <= `FETCH_START_ADDRESS;
            iaddr_jumped_r <= `FETCH_START_ADDRESS;
        end else begin
            if (jumped) begin
                iaddr_jumped <= iaddr_aligned;
            end
            if (jumped_r) begin
                iaddr_jumped_r <= iaddr_jumped;
            end
        end
    end

    assign pc_update = jumped_r2 ? iaddr_jumped_r : (pc_o + 32'd4);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o <= '0;
        end else if (sys_reset_i) begin
            pc_o <= '0;
        end else if (enable_i) begin
            pc_o <= pc_update;
        end
    end

    ////////////////////
    // Data control
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_r <= 1'b0;
        end else if (sys_reset_i) begin
            enable_r <= 1'b0;
        end else begin
            enable_r <= enable_i;
        end
    end

    // Word returned in the first stalled cycle is replayed on resume
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idata_held <= `NOP_WORD;
        end else if (sys_reset_i) begin
            idata_held <= `NOP_WORD;
        end else if (!enable_i && enable_r) begin
            idata_held <= instruction_data_i;
        end
    end

    assign instruction_fetched = enable_r ? instruction_data_i : idata_held;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= `NOP_WORD;
        end else if (sys_reset_i) begin
            instruction_o <= `NOP_WORD;
        end else if (enable_i) begin
            instruction_o <= instruction_fetched;
        end
    end

    ////////////////////
    // Tag control
    ////////////////////

    // Counts redirects and rides two enabled stages with its word
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag   <= '0;
            tag_r <= '1;
            tag_o <= '1;
        end else if (sys_reset_i) begin
            tag   <= '0;
            tag_r <= '1;
            tag_o <= '1;
        end else begin
            if (jumped) begin
                tag <= tag + 1'b1;
            end
            if (enable_i) begin
                tag_r <= tag;
                tag_o <= tag_r;
            end
        end
    end

endmodule

// File: verilog/jal_predecoder.sv
`timescale 1ns/1ns
/*
 * Static JAL predictor
 * Decodes the J-type immediate of the presented instruction
 * Issues a one-cycle take with the jump target
 */

module jal_predecoder (
    input  logic              bubble_i,
    input  logic              advance_i,
    input  fetch_pkg::word_t  instruction_i,
    input  fetch_pkg::word_t  pc_i,
    output logic              take_o,
    output fetch_pkg::word_t  target_o
);

    import fetch_pkg::*;

    logic  is_jal;
    word_t j_imm;

    ////////////////////
    // Decode
    ////////////////////

    assign is_jal = (instruction_i[6:0] == OPCODE_JAL);

    // imm[20|10:1|11|19:12] scattered over bits 31:12
    assign j_imm = {
        {12{instruction_i[31]}},
        instruction_i[19:12],
        instruction_i[20],
        instruction_i[30:21],
        1'b0
    };

    ////////////////////
    // Prediction
    ////////////////////

    assign target_o = pc_i + j_imm;

    // A JAL always jumps, so the prediction is never wrong.
    // Only a valid word leaving this cycle may redirect, which
    // gives exactly one pulse per JAL
    assign take_o = is_jal && !bubble_i && advance_i;

endmodule

// File: verilog/instr_mem.sv
`timescale 1ns/1ns
/*
 * Instruction memory
 * One registered read port for the fetch unit
 * One write port used to load programs
 */

module instr_mem (
    input  logic                    clk,

    // Fetch side
    input  fetch_pkg::imem_index_t  read_index_i,
    output fetch_pkg::word_t        read_data_o,

    // Program load side
    input  logic                    write_en_i,
    input  fetch_pkg::imem_index_t  write_index_i,
    input  fetch_pkg::word_t        write_data_i
);

    import fetch_pkg::*;

    localparam int DEPTH = 2 ** $bits(imem_index_t);

    word_t mem [DEPTH];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (write_en_i) begin
            mem[write_index_i] <= write_data_i;
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    // One cycle of latency
    // A read of the word being written returns the old contents
    always_ff @(posedge clk) begin
        read_data_o <= mem[read_index_i];
    end

endmodule

// File: verilog/fetch_pkg.sv
/*
 * Shared fetch front end types
 * Address and instruction words, redirect tag, memory word index
 * Major opcode of JAL
 */
package fetch_pkg;

    `include "fetch_defines.svh"

    ////////////////////
    // Types
    ////////////////////

    // Address or instruction word
    typedef logic [31:0] word_t;

    // Redirect tag, travels with each instruction
    typedef logic [`TAG_WIDTH-1:0] tag_t;

    // Word index into the instruction memory
    typedef logic [`IMEM_ADDR_BITS-1:0] imem_index_t;

    ////////////////////
    // Opcodes
    ////////////////////

    // J-type, rd = pc + 4, pc += imm
    localparam logic [6:0] OPCODE_JAL = 7'b1101111;

endpackage

// File: include/fetch_defines.svh
/*
 * Fetch front end configuration macros
 * Start address, instruction memory depth, redirect tag width, NOP encoding
 */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Address fetched out of reset and after sys_reset
`define FETCH_START_ADDRESS 32'h0000_0000

// Word-index bits of the instruction memory, 256 words
`define IMEM_ADDR_BITS 8

// Redirect tag counts modulo 8
`define TAG_WIDTH 3

// addi x0, x0, 0
`define NOP_WORD 32'h0000_0013

`endif
